// File: src/afifo_macros.svh
`ifndef AFIFO_MACROS_SVH
`define AFIFO_MACROS_SVH

// FIFO geometry. Depth must stay a power of two.
`define AFIFO_DEPTH   16
`define AFIFO_ADDR_W  4

// Flag thresholds in entries.
`define AFIFO_AFULL   14
`define AFIFO_AEMPTY  1

// Payload field widths.
`define AFIFO_TAG_W   4
`define AFIFO_DATA_W  16

`endif

// File: src/afifo_pkg.sv
`default_nettype none

`include "afifo_macros.svh"

package afifo_pkg;

  // Extra top bit marks a wrapped pointer.
  typedef logic [`AFIFO_ADDR_W:0] ptr_t;

  // Default payload word.
  typedef struct packed {
    logic [`AFIFO_TAG_W-1:0]  tag;
    logic [`AFIFO_DATA_W-1:0] data;
  } word_t;

endpackage

`default_nettype wire

// File: src/afifo_dpram.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_dpram #(
  parameter type payload_t = afifo_pkg::word_t
) (
  input  logic                     wr_clk,
  input  logic                     wr_en,
  input  logic [`AFIFO_ADDR_W-1:0] wr_addr,
  input  payload_t                 wr_data,
  input  logic                     rd_clk,
  input  logic                     rd_en,
  input  logic [`AFIFO_ADDR_W-1:0] rd_addr,
  output payload_t                 rd_data
);

  payload_t mem [`AFIFO_DEPTH];

  // Address width has to cover the whole array.
  if ((1 << `AFIFO_ADDR_W) != `AFIFO_DEPTH) begin : g_depth_check
    $error("AFIFO_DEPTH does not match AFIFO_ADDR_W");
  end

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port.
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: src/afifo_gray_sync.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_gray_sync (
  input  logic            src_clk,
  input  logic            src_rst_n,
  input  afifo_pkg::ptr_t src_ptr,
  input  logic            dst_clk,
  input  logic            dst_rst_n,
  output afifo_pkg::ptr_t dst_ptr
);

  afifo_pkg::ptr_t src_gray;
  afifo_pkg::ptr_t dst_meta;
  afifo_pkg::ptr_t dst_gray;

  always_ff @(posedge src_clk) begin
    if (!src_rst_n) begin
      src_gray <= '0;
    end else begin
      src_gray <= src_ptr ^ (src_ptr >> 1); // Binary to Gray.
    end
  end

  // Two flop synchronizer.
  always_ff @(posedge dst_clk) begin
    if (!dst_rst_n) begin
      dst_meta <= '0;
      dst_gray <= '0;
    end else begin
      dst_meta <= src_gray;
      dst_gray <= dst_meta;
    end
  end

  // Each binary bit is the XOR of the Gray bits at and above it.
  always_comb begin
    for (int i = 0; i <= `AFIFO_ADDR_W; i++) begin
      dst_ptr[i] = ^(dst_gray >> i);
    end
  end

  // Only a one bit change is safe to sample in the other domain.
  gray_one_step_a: assert property (@(posedge src_clk) disable iff (!src_rst_n)
    $countones(src_gray ^ $past(src_gray)) <= 1)
    else $error("Gray pointer moved by more than one bit");

endmodule

`default_nettype wire

// File: src/afifo_wr_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_wr_ctrl (
  input  logic                     wr_clk,
  input  logic                     wr_rst_n,
  input  logic                     wr_en,
  input  afifo_pkg::ptr_t          rd_ptr_sync,
  output afifo_pkg::ptr_t          wr_ptr,
  output logic                     ram_wr_en,
  output logic [`AFIFO_ADDR_W-1:0] ram_wr_addr,
  output logic                     full,
  output logic                     afull
);

  logic            wr_accept;
  afifo_pkg::ptr_t wr_ptr_nxt;
  afifo_pkg::ptr_t used_nxt;
  afifo_pkg::ptr_t rd_ptr_wrap;

  assign wr_accept  = wr_en && !full; // Writes while full are dropped.
  assign wr_ptr_nxt = wr_ptr + afifo_pkg::ptr_t'(wr_accept);
  assign used_nxt   = wr_ptr_nxt - rd_ptr_sync;

  // Read pointer one lap behind.
  assign rd_ptr_wrap = {~rd_ptr_sync[`AFIFO_ADDR_W], rd_ptr_sync[`AFIFO_ADDR_W-1:0]};

  // Flags come from the next pointer so full never lags its own writes.
  always_ff @(posedge wr_clk) begin
    if (!wr_rst_n) begin
      wr_ptr <= '0;
      full   <= 1'b0;
      afull  <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr_nxt;
      full   <= (wr_ptr_nxt == rd_ptr_wrap);
      afull  <= (used_nxt >= afifo_pkg::ptr_t'(`AFIFO_AFULL));
    end
  end

  assign ram_wr_en   = wr_accept;
  assign ram_wr_addr = wr_ptr[`AFIFO_ADDR_W-1:0];

  // Write pointer never laps the read pointer.
  wr_hold_when_full_a: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    (wr_ptr - rd_ptr_sync) <= afifo_pkg::ptr_t'(`AFIFO_DEPTH))
    else $error("Write pointer ran past a full FIFO");

  // A FIFO at depth always shows full.
  full_at_depth_a: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    ((wr_ptr - rd_ptr_sync) == afifo_pkg::ptr_t'(`AFIFO_DEPTH)) |-> full)
    else $error("Full clear at depth");

endmodule

`default_nettype wire

// File: src/afifo_rd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_macros.svh"

module afifo_rd_ctrl (
  input  logic                     rd_clk,
  input  logic                     rd_rst_n,
  input  logic                     rd_en,
  input  afifo_pkg::ptr_t          wr_ptr_sync,
  output afifo_pkg::ptr_t          rd_ptr,
  output logic                     ram_rd_en,
  output logic [`AFIFO_ADDR_W-1:0] ram_rd_addr,
  output logic                     empty,
  output logic                     aempty,
  output logic                     rd_valid
);

  logic            rd_accept;
  afifo_pkg::ptr_t rd_ptr_nxt;
  afifo_pkg::ptr_t used_nxt;

  assign rd_accept  = rd_en && !empty;
  assign rd_ptr_nxt = rd_ptr + afifo_pkg::ptr_t'(rd_accept);

  // Entries left after this pop.
  assign used_nxt = wr_ptr_sync - rd_ptr_nxt;

  always_ff @(posedge rd_clk) begin
    if (!rd_rst_n) begin
      rd_ptr   <= '0;
      empty    <= 1'b1;
      aempty   <= 1'b1;
      rd_valid <= 1'b0;
    end else begin
      rd_ptr   <= rd_ptr_nxt;
      empty    <= (rd_ptr_nxt == wr_ptr_sync);
      aempty   <= (used_nxt <= afifo_pkg::ptr_t'(`AFIFO_AEMPTY));
      rd_valid <= rd_accept; // Lines up with the RAM output register.
    end
  end

  // RAM reads at the pop edge.
  assign ram_rd_en   = rd_accept;
  assign ram_rd_addr = rd_ptr[`AFIFO_ADDR_W-1:0];

  // Read pointer never passes the write pointer.
  rd_hold_when_empty_a: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    (wr_ptr_sync - rd_ptr) <= afifo_pkg::ptr_t'(`AFIFO_DEPTH))
    else $error("Read pointer advanced past the write pointer");

endmodule

`default_nettype wire

// File: src/async_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_macros.svh"

module async_fifo #(
  parameter type payload_t = afifo_pkg::word_t
) (
  input  logic     wr_clk,
  input  logic     wr_rst_n,
  input  logic     wr_en,
  input  payload_t wr_data,
  input  logic     rd_clk,
  input  logic     rd_rst_n,
  input  logic     rd_en,
  output payload_t rd_data,
  output logic     rd_valid,
  output logic     full,
  output logic     afull,
  output logic     empty,
  output logic     aempty
);

  afifo_pkg::ptr_t           wr_ptr;
  afifo_pkg::ptr_t           rd_ptr;
  afifo_pkg::ptr_t           wr_ptr_sync; // Write pointer seen in rd_clk.
  afifo_pkg::ptr_t           rd_ptr_sync; // Read pointer seen in wr_clk.
  logic                      ram_wr_en;
  logic [`AFIFO_ADDR_W-1:0]  ram_wr_addr;
  logic                      ram_rd_en;
  logic [`AFIFO_ADDR_W-1:0]  ram_rd_addr;

  afifo_dpram #(
    .payload_t (payload_t)
  ) ram_i (
    .wr_clk  (wr_clk),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (ram_rd_en),
    .rd_addr (ram_rd_addr),
    .rd_data (rd_data)
  );

  afifo_wr_ctrl wr_ctrl_i (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_sync (rd_ptr_sync),
    .wr_ptr      (wr_ptr),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .full        (full),
    .afull       (afull)
  );

  afifo_rd_ctrl rd_ctrl_i (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_sync (wr_ptr_sync),
    .rd_ptr      (rd_ptr),
    .ram_rd_en   (ram_rd_en),
    .ram_rd_addr (ram_rd_addr),
    .empty       (empty),
    .aempty      (aempty),
    .rd_valid    (rd_valid)
  );

  afifo_gray_sync w2r_sync_i (
    .src_clk   (wr_clk),
    .src_rst_n (wr_rst_n),
    .src_ptr   (wr_ptr),
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .dst_ptr   (wr_ptr_sync)
  );

  afifo_gray_sync r2w_sync_i (
    .src_clk   (rd_clk),
    .src_rst_n (rd_rst_n),
    .src_ptr   (rd_ptr),
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .dst_ptr   (rd_ptr_sync)
  );

endmodule

`default_nettype wire

// File: verification/async_fifo_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "afifo_macros.svh"

module async_fifo_tb;

  logic             wr_clk;
  logic             rd_clk;
  logic             wr_rst_n;
  logic             rd_rst_n;
  logic             wr_en;
  logic             rd_en;
  afifo_pkg::word_t wr_data;
  afifo_pkg::word_t rd_data;
  logic             rd_valid;
  logic             full;
  logic             afull;
  logic             empty;
  logic             aempty;

  afifo_pkg::word_t model_q[$]; // Accepted writes, oldest first.
  afifo_pkg::word_t exp_word;
  int               wr_count = 0;
  int               pop_count = 0;
  logic             wr_done = 1'b0;

  async_fifo #(
    .payload_t (afifo_pkg::word_t)
  ) dut_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #4 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #5.5 rd_clk = ~rd_clk; // Unrelated to wr_clk.
  end

  task automatic mismatch_abort(input string what);
    $display("MISMATCH at %0t: %s", $time, what);
    $display("Regression failed");
    $fatal(1, "Stopped at first error.");
  endtask

  task automatic fail_abort(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("Regression failed");
    $fatal(1, "Stopped at first error.");
  endtask

  task automatic expect_flag(input logic actual, input logic expected, input string what);
    assert (actual === expected)
      else mismatch_abort($sformatf("%s is %b, expected %b", what, actual, expected));
  endtask

  task automatic expect_count(input int actual, input int expected, input string what);
    assert (actual == expected)
      else mismatch_abort($sformatf("%s is %0d, expected %0d", what, actual, expected));
  endtask

  function automatic afifo_pkg::word_t random_word();
    afifo_pkg::word_t w;
    w.tag  = `AFIFO_TAG_W'($urandom);
    w.data = `AFIFO_DATA_W'($urandom);
    return w;
  endfunction

  // Reference model. The oldest accepted write comes out next.
  function automatic afifo_pkg::word_t expected_word();
    return model_q.pop_front();
  endfunction

  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      model_q.push_back(wr_data);
      wr_count <= wr_count + 1;
    end
  end

  always @(posedge rd_clk) begin
    if (rd_rst_n && rd_valid) begin
      assert (model_q.size() > 0)
        else fail_abort("rd_valid was high with no word written");
      exp_word = expected_word();
      assert (rd_data == exp_word)
        else mismatch_abort($sformatf("rd_data %h, expected %h", rd_data, exp_word));
      pop_count <= pop_count + 1;
    end
  end

  initial begin
    int n;
    int pops;
    int gap;
    int rd_cycles;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    void'($urandom(19932));
    repeat (4) @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    @(posedge rd_clk);
    rd_rst_n <= 1'b1;
    repeat (3) @(posedge rd_clk);
    expect_flag(empty, 1'b1, "empty after reset");
    expect_flag(aempty, 1'b1, "aempty after reset");
    expect_flag(rd_valid, 1'b0, "rd_valid after reset");
    @(posedge wr_clk);
    expect_flag(full, 1'b0, "full after reset");
    expect_flag(afull, 1'b0, "afull after reset");

    // Fill with reads idle. Flags must track the accepted count exactly.
    n = 0;
    do begin
      @(posedge wr_clk);
      expect_flag(full, wr_count == `AFIFO_DEPTH, "full during fill");
      expect_flag(afull, wr_count >= `AFIFO_AFULL, "afull during fill");
      if (!full) begin
        wr_en   <= 1'b1;
        wr_data <= random_word();
      end
      n++;
    end while (!full && n < 200);
    if (!full) fail_abort("full never rose while filling");
    repeat (3) begin
      @(posedge wr_clk);
      expect_flag(full, 1'b1, "full during dropped writes");
      expect_count(wr_count, `AFIFO_DEPTH, "accepted writes while full");
      wr_data <= random_word();
    end
    wr_en <= 1'b0;
    @(posedge wr_clk);
    expect_count(wr_count, `AFIFO_DEPTH, "accepted writes after drops");

    n = 0;
    do begin
      @(posedge rd_clk);
      n++;
    end while (empty && n < 200);
    if (empty) fail_abort("empty never fell after the fill");
    repeat (6) @(posedge rd_clk); // Write pointer settles.

    // Drain in order.
    pops = 0;
    n = 0;
    do begin
      @(posedge rd_clk);
      expect_flag(empty, pops == `AFIFO_DEPTH, "empty during drain");
      expect_flag(aempty, (`AFIFO_DEPTH - pops) <= `AFIFO_AEMPTY, "aempty during drain");
      if (rd_en && !empty) pops++;
      rd_en <= 1'b1;
      n++;
    end while (!empty && n < 200);
    if (!empty) fail_abort("empty never rose while draining");
    expect_count(pops, `AFIFO_DEPTH, "pops until empty");

    // Reads against an empty FIFO.
    repeat (10) begin
      @(posedge rd_clk);
      expect_flag(rd_valid, 1'b0, "rd_valid while empty");
      expect_count(model_q.size(), 0, "model size during empty reads");
    end
    rd_en <= 1'b0;
    expect_count(pop_count, `AFIFO_DEPTH, "words popped after drain");

    fork
      begin
        @(posedge wr_clk);
        for (int i = 0; i < 400; i++) begin
          wr_en   <= 1'b1;
          wr_data <= random_word();
          n = 0;
          do begin
            @(posedge wr_clk);
            n++;
          end while (full && n < 200);
          if (full) fail_abort("random write never accepted, full stayed high");
          gap = $urandom_range(3, 0);
          repeat (gap) begin
            wr_en <= 1'b0;
            @(posedge wr_clk);
          end
        end
        wr_en   <= 1'b0;
        wr_done = 1'b1;
      end
      begin
        rd_cycles = 0;
        while (!wr_done) begin
          @(posedge rd_clk);
          rd_en <= ($urandom_range(2, 0) != 0);
          rd_cycles++;
          if (rd_cycles > 20000) fail_abort("random traffic never finished");
        end
      end
    join

    repeat (6) @(posedge rd_clk); // Write pointer settles.
    rd_en <= 1'b1;
    n = 0;
    do begin
      @(posedge rd_clk);
      n++;
    end while (!empty && n < 200);
    if (!empty) fail_abort("empty never rose after random traffic");
    rd_en <= 1'b0;
    @(posedge rd_clk); // Last word leaves the read register.
    expect_count(pop_count, wr_count, "pops against accepted writes after drain");
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/afifo_pkg.sv
src/afifo_dpram.sv
src/afifo_gray_sync.sv
src/afifo_wr_ctrl.sv
src/afifo_rd_ctrl.sv
src/async_fifo.sv
verification/async_fifo_tb.sv

// File: run.sh
#!/bin/sh
# Builds the async FIFO testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module async_fifo_tb -f src.f \
    -o async_fifo_sim &&
  ./obj_dir/async_fifo_sim | tee /dev/stderr | grep "Regression passed" > /dev/null &&
  echo "Simulation run OK" ||
  { echo "Simulation run FAILED"; exit 1; }
